// File: fp_pkg.sv
package fp_pkg;

  // Field widths of an IEEE binary32 word.
  localparam int EXP_W = 8;
  localparam int MAN_W = 23;

  // Width of the fflags word, in RISC-V order.
  localparam int FLAG_W = 5;

  // Bit positions inside fflags.
  localparam int FLAG_NX = 0;
  localparam int FLAG_OF = 2;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp32_fields_t;

  // One binary32 word, seen either as raw bits or as its fields.
  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t fields;
  } fp32_t;

  // OP_RSUB computes rs2 minus rs1.
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_RSUB = 2'd2
  } fp_op_e;

endpackage

// File: fpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  fp_pkg::fp_op_e              op,
  input  logic                        flags_clr,
  input  logic                        nx,
  input  logic                        of,
  output logic                        neg_b,
  output logic                        swap_in,
  output logic                        v1,
  output logic                        v2,
  output logic                        v3,
  output logic                        out_valid,
  output logic [fp_pkg::FLAG_W-1:0]   out_flags,
  output logic [fp_pkg::FLAG_W-1:0]   fflags
);

  import fp_pkg::*;

  logic [2:0]        vpipe;
  logic [FLAG_W-1:0] flags_now;

  // RSUB swaps the operands and then negates the new second one.
  assign swap_in = (op == OP_RSUB);
  assign neg_b   = (op == OP_SUB) || (op == OP_RSUB);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vpipe <= '0;
    end else begin
      vpipe <= {vpipe[1:0], in_valid};
    end
  end

  assign v1        = vpipe[0];
  assign v2        = vpipe[1];
  assign v3        = vpipe[2];
  assign out_valid = vpipe[2];

  always_comb begin
    flags_now          = '0;
    flags_now[FLAG_NX] = nx;
    flags_now[FLAG_OF] = of;
  end

  // The rounding stage reports its flags while it loads rd.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_flags <= '0;
    end else if (v2) begin
      out_flags <= flags_now;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fflags <= '0;
    end else if (flags_clr) begin
      fflags <= '0;
    end else if (out_valid) begin
      fflags <= fflags | out_flags;
    end
  end

  // Stage 2 must hold a loaded operation whenever the rounding flags are taken.
  a_round_flags_known: assert property (@(posedge clk) disable iff (!rst_n)
    v2 |-> !$isunknown({nx, of}));

  a_in_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(in_valid));

endmodule

`default_nettype wire

// File: fp_align.sv
`timescale 1ns/1ps
`default_nettype none

module fp_align (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  fp_pkg::fp32_t                 rs1,
  input  fp_pkg::fp32_t                 rs2,
  input  logic                          neg_b,
  input  logic                          swap_in,
  output logic [fp_pkg::MAN_W+1:0]      big_man,
  output logic [fp_pkg::MAN_W+3:0]      small_man,
  output logic [fp_pkg::EXP_W-1:0]      big_exp,
  output logic                          res_sign,
  output logic                          eff_sub,
  output logic                          sticky,
  output logic                          zero_sign
);

  import fp_pkg::*;

  // Extended mantissa holds a carry bit, the hidden bit and the fraction.
  localparam int XW = MAN_W + 2;
  // The shifter keeps 31 bits below the mantissa to catch everything dropped.
  localparam int SW = XW + 31;

  fp32_t            a;
  fp32_t            b;
  logic [EXP_W-1:0] ea;
  logic [EXP_W-1:0] eb;
  logic [XW-1:0]    ma;
  logic [XW-1:0]    mb;
  logic             a_big;
  logic [EXP_W-1:0] diff;
  logic [4:0]       shamt;
  logic [SW-1:0]    wide;

  always_comb begin
    a = swap_in ? rs2 : rs1;
    b = swap_in ? rs1 : rs2;
    b.fields.sign = b.fields.sign ^ neg_b;

    // Subnormals sit at exponent one with no hidden bit.
    ea = (a.fields.exp == '0) ? EXP_W'(1) : a.fields.exp;
    eb = (b.fields.exp == '0) ? EXP_W'(1) : b.fields.exp;
    ma = {1'b0, a.fields.exp != '0, a.fields.man};
    mb = {1'b0, b.fields.exp != '0, b.fields.man};

    a_big = (ea > eb) || ((ea == eb) && (ma >= mb));
    diff  = a_big ? (ea - eb) : (eb - ea);
    shamt = (diff > EXP_W'(31)) ? 5'd31 : diff[4:0];

    wide = {(a_big ? mb : ma), 31'b0} >> shamt;
  end

  always_ff @(posedge clk) begin
    if (en) begin
      big_man   <= a_big ? ma : mb;
      big_exp   <= a_big ? ea : eb;
      res_sign  <= a_big ? a.fields.sign : b.fields.sign;
      small_man <= wide[SW-1:SW-XW-2];
      sticky    <= |wide[SW-XW-3:0];
      eff_sub   <= a.fields.sign ^ b.fields.sign;
      zero_sign <= a.fields.sign & b.fields.sign;
    end
  end

  // After alignment the smaller operand never exceeds the larger one.
  a_big_not_smaller: assert property (@(posedge clk) disable iff (!rst_n)
    en |=> ({big_man, 2'b00} >= small_man));

endmodule

`default_nettype wire

// File: fp_addmant.sv
`timescale 1ns/1ps
`default_nettype none

module fp_addmant (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [fp_pkg::MAN_W+1:0]      big_man,
  input  logic [fp_pkg::MAN_W+3:0]      small_man,
  input  logic [fp_pkg::EXP_W-1:0]      big_exp,
  input  logic                          res_sign,
  input  logic                          eff_sub,
  input  logic                          sticky,
  input  logic                          zero_sign,
  output logic [fp_pkg::MAN_W+3:0]      sum_man,
  output logic [fp_pkg::EXP_W-1:0]      sum_exp,
  output logic [4:0]                    lz,
  output logic                          res_sign_q,
  output logic                          sticky_q,
  output logic                          zero_sign_q
);

  import fp_pkg::*;

  localparam int SUM_W = MAN_W + 4;

  logic [SUM_W-1:0] raw;
  logic [SUM_W-1:0] norm;
  logic [EXP_W-1:0] exp_c;
  logic             st_c;
  logic [4:0]       lz_c;

  always_comb begin
    // A set sticky means the true subtrahend is a little larger, so borrow one
    // more at the round position and keep sticky for the remainder.
    if (eff_sub) begin
      raw = {big_man, 2'b00} - small_man - SUM_W'(sticky);
    end else begin
      raw = {big_man, 2'b00} + small_man;
    end

    if (raw[SUM_W-1]) begin
      norm  = raw >> 1;
      exp_c = big_exp + EXP_W'(1);
      st_c  = sticky | raw[0];
    end else begin
      norm  = raw;
      exp_c = big_exp;
      st_c  = sticky;
    end

    // Zeros above the hidden-bit position; 26 means the sum is zero.
    lz_c = 5'd26;
    for (int i = 0; i <= SUM_W - 2; i++) begin
      if (norm[i]) begin
        lz_c = 5'(SUM_W - 2 - i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      sum_man     <= norm;
      sum_exp     <= exp_c;
      lz          <= lz_c;
      res_sign_q  <= res_sign;
      sticky_q    <= st_c;
      zero_sign_q <= zero_sign;
    end
  end

  a_sub_no_carry: assert property (@(posedge clk) disable iff (!rst_n)
    (en && eff_sub) |-> !raw[SUM_W-1]);

endmodule

`default_nettype wire

// File: fp_round.sv
`timescale 1ns/1ps
`default_nettype none

module fp_round (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [fp_pkg::MAN_W+3:0]      sum_man,
  input  logic [fp_pkg::EXP_W-1:0]      sum_exp,
  input  logic [4:0]                    lz,
  input  logic                          res_sign,
  input  logic                          sticky,
  input  logic                          zero_sign,
  output fp_pkg::fp32_t                 rd,
  output logic                          nx,
  output logic                          of
);

  import fp_pkg::*;

  logic [4:0]       shamt;
  logic [EXP_W-1:0] exp_n;
  logic [MAN_W+3:0] norm;
  logic             lsb;
  logic             g;
  logic             r;
  logic             up;
  logic [MAN_W+1:0] rnd;
  logic [EXP_W:0]   exp_r;
  fp32_t            res;

  always_comb begin
    // Stop the left shift at the subnormal limit.
    if (sum_exp > EXP_W'(lz)) begin
      shamt = lz;
      exp_n = sum_exp - EXP_W'(lz);
    end else begin
      shamt = sum_exp[4:0] - 5'd1;
      exp_n = '0;
    end
    norm = sum_man << shamt;

    lsb = norm[2];
    g   = norm[1];
    r   = norm[0];
    up  = g & (r | sticky | lsb);
    rnd = {1'b0, norm[MAN_W+2:2]} + (MAN_W + 2)'(up);

    // A subnormal that rounds up into the hidden bit becomes normal.
    if (exp_n == '0) begin
      exp_r = (EXP_W + 1)'(rnd[MAN_W]);
    end else begin
      exp_r = {1'b0, exp_n} + (EXP_W + 1)'(rnd[MAN_W+1]);
    end

    of = (exp_r >= (EXP_W + 1)'(255));
    nx = g | r | sticky | of;

    res.fields.sign = res_sign;
    if (of) begin
      res.fields.exp = '1;
      res.fields.man = '0;
    end else if (rnd == '0) begin
      res.fields.sign = zero_sign;
      res.fields.exp  = '0;
      res.fields.man  = '0;
    end else begin
      res.fields.exp = exp_r[EXP_W-1:0];
      res.fields.man = rnd[MAN_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd <= '0;
    end else if (en) begin
      rd <= res;
    end
  end

endmodule

`default_nettype wire

// File: fp_addsub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  fp_pkg::fp_op_e              op,
  input  logic [31:0]                 rs1,
  input  logic [31:0]                 rs2,
  input  logic                        flags_clr,
  output logic                        out_valid,
  output logic [31:0]                 rd,
  output logic [fp_pkg::FLAG_W-1:0]   out_flags,
  output logic [fp_pkg::FLAG_W-1:0]   fflags
);

  import fp_pkg::*;

  logic             neg_b;
  logic             swap_in;
  logic             v1;
  logic             v2;
  logic             nx;
  logic             of;

  // Stage 1 to stage 2.
  logic [MAN_W+1:0] s1_big_man;
  logic [MAN_W+3:0] s1_small_man;
  logic [EXP_W-1:0] s1_big_exp;
  logic             s1_res_sign;
  logic             s1_eff_sub;
  logic             s1_sticky;
  logic             s1_zero_sign;

  // Stage 2 to stage 3.
  logic [MAN_W+3:0] s2_sum_man;
  logic [EXP_W-1:0] s2_sum_exp;
  logic [4:0]       s2_lz;
  logic             s2_res_sign;
  logic             s2_sticky;
  logic             s2_zero_sign;

  fpu_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .flags_clr (flags_clr),
    .nx        (nx),
    .of        (of),
    .neg_b     (neg_b),
    .swap_in   (swap_in),
    .v1        (v1),
    .v2        (v2),
    .v3        (),
    .out_valid (out_valid),
    .out_flags (out_flags),
    .fflags    (fflags)
  );

  fp_align u_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (in_valid),
    .rs1       (rs1),
    .rs2       (rs2),
    .neg_b     (neg_b),
    .swap_in   (swap_in),
    .big_man   (s1_big_man),
    .small_man (s1_small_man),
    .big_exp   (s1_big_exp),
    .res_sign  (s1_res_sign),
    .eff_sub   (s1_eff_sub),
    .sticky    (s1_sticky),
    .zero_sign (s1_zero_sign)
  );

  fp_addmant u_addmant (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (v1),
    .big_man     (s1_big_man),
    .small_man   (s1_small_man),
    .big_exp     (s1_big_exp),
    .res_sign    (s1_res_sign),
    .eff_sub     (s1_eff_sub),
    .sticky      (s1_sticky),
    .zero_sign   (s1_zero_sign),
    .sum_man     (s2_sum_man),
    .sum_exp     (s2_sum_exp),
    .lz          (s2_lz),
    .res_sign_q  (s2_res_sign),
    .sticky_q    (s2_sticky),
    .zero_sign_q (s2_zero_sign)
  );

  fp_round u_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (v2),
    .sum_man   (s2_sum_man),
    .sum_exp   (s2_sum_exp),
    .lz        (s2_lz),
    .res_sign  (s2_res_sign),
    .sticky    (s2_sticky),
    .zero_sign (s2_zero_sign),
    .rd        (rd),
    .nx        (nx),
    .of        (of)
  );

endmodule

`default_nettype wire

// File: tb_fp_addsub.sv
`timescale 1ns/1ps

module tb_fp_addsub;

  import fp_pkg::*;

  localparam int N_VEC      = 15;
  localparam int CLR_AT     = 8;
  localparam int RAND_PAIRS = 200;
  localparam int RAND_OPS   = 5 * RAND_PAIRS;
  localparam int TIMEOUT_NS = (N_VEC + RAND_OPS + 20) * 8;

  typedef struct packed {
    fp_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_rd;
    logic [4:0]  exp_fl;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  fp_op_e      op;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic        flags_clr;
  logic        out_valid;
  logic [31:0] rd;
  logic [4:0]  out_flags;
  logic [4:0]  fflags;

  int          edge_cnt;
  int          errors;
  logic [4:0]  flags_model;
  vec_t        vectors [N_VEC];

  // One entry per operation still in flight, oldest first.
  int          issue_q [$];
  int          tag_q [$];
  logic [31:0] exp_rd_q [$];
  logic [4:0]  exp_fl_q [$];

  logic [31:0] res_rd [RAND_OPS];
  logic [4:0]  res_fl [RAND_OPS];

  fp_addsub_unit u_fp_addsub_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .rs1       (rs1),
    .rs2       (rs2),
    .flags_clr (flags_clr),
    .out_valid (out_valid),
    .rd        (rd),
    .out_flags (out_flags),
    .fflags    (fflags)
  );

  // The edge count moves before the clock rises, so every process woken by
  // the edge sees the number of that edge.
  initial begin
    clk      = 1'b0;
    edge_cnt = 0;
    forever begin
      #4;
      edge_cnt = edge_cnt + 1;
      clk = 1'b1;
      #4;
      clk = 1'b0;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    errors = errors + 1;
    $display("%0t ns %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "protocol failure");
  endtask

  task automatic fill_vectors();
    // Directed cases with their expected results and flags.
    vectors[0]  = '{OP_ADD,  32'h3F800000, 32'h40000000, 32'h40400000, 5'h00};
    vectors[1]  = '{OP_SUB,  32'h40400000, 32'h3F800000, 32'h40000000, 5'h00};
    vectors[2]  = '{OP_RSUB, 32'h3F800000, 32'h40400000, 32'h40000000, 5'h00};
    vectors[3]  = '{OP_SUB,  32'h3F800000, 32'h3F800000, 32'h00000000, 5'h00};
    vectors[4]  = '{OP_ADD,  32'h80000000, 32'h80000000, 32'h80000000, 5'h00};
    vectors[5]  = '{OP_ADD,  32'h3F800000, 32'h33800000, 32'h3F800000, 5'h01};
    vectors[6]  = '{OP_ADD,  32'h3F800000, 32'h34400000, 32'h3F800002, 5'h01};
    vectors[7]  = '{OP_ADD,  32'h3DCCCCCD, 32'h3E4CCCCD, 32'h3E99999A, 5'h01};
    vectors[8]  = '{OP_ADD,  32'h00000001, 32'h00000001, 32'h00000002, 5'h00};
    vectors[9]  = '{OP_SUB,  32'h00800000, 32'h007FFFFF, 32'h00000001, 5'h00};
    vectors[10] = '{OP_SUB,  32'h3F800001, 32'h3F800000, 32'h34000000, 5'h00};
    vectors[11] = '{OP_SUB,  32'h3F800000, 32'h3F7FFFFF, 32'h33800000, 5'h00};
    vectors[12] = '{OP_ADD,  32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 5'h05};
    vectors[13] = '{OP_ADD,  32'h3F800000, 32'hC0200000, 32'hBFC00000, 5'h00};
    vectors[14] = '{OP_RSUB, 32'h40400000, 32'h3F800000, 32'hC0000000, 5'h00};
  endtask

  task automatic issue(input fp_op_e o, input logic [31:0] a, input logic [31:0] b,
                       input logic clr, input int tag,
                       input logic [31:0] exp_rd, input logic [4:0] exp_fl);
    @(posedge clk);
    in_valid  <= 1'b1;
    op        <= o;
    rs1       <= a;
    rs2       <= b;
    flags_clr <= clr;
    issue_q.push_back(edge_cnt);
    tag_q.push_back(tag);
    exp_rd_q.push_back(exp_rd);
    exp_fl_q.push_back(exp_fl);
  endtask

  task automatic wait_drain();
    @(posedge clk);
    in_valid  <= 1'b0;
    flags_clr <= 1'b0;
    while (issue_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  function automatic logic [31:0] rand_normal();
    fp32_t w;
    w.fields.sign = 1'($urandom);
    w.fields.exp  = 8'(1 + $urandom % 254);
    w.fields.man  = 23'($urandom);
    return w.bits;
  endfunction

  // Outputs are read at the falling edge, half a cycle after they settle.
  always @(negedge clk) begin
    if (rst_n) begin
      check_val("fflags", 32'(fflags), 32'(flags_model));
      if (out_valid) begin
        if (issue_q.size() == 0) begin
          report_failure("out_valid was high with no operation in flight.");
        end else begin
          check_val("latency", 32'(edge_cnt - issue_q[0]), 32'd3);
          if (tag_q[0] < 0) begin
            check_val("rd", rd, exp_rd_q[0]);
            check_val("out_flags", 32'(out_flags), 32'(exp_fl_q[0]));
          end else begin
            res_rd[tag_q[0]] = rd;
            res_fl[tag_q[0]] = out_flags;
          end
          void'(issue_q.pop_front());
          void'(tag_q.pop_front());
          void'(exp_rd_q.pop_front());
          void'(exp_fl_q.pop_front());
        end
      end else if (issue_q.size() != 0 && edge_cnt - issue_q[0] > 3) begin
        report_failure("A result did not appear three cycles after its strobe.");
      end
      // The clear wins over a flag update in the same cycle.
      if (flags_clr) begin
        flags_model = '0;
      end else if (out_valid) begin
        flags_model = flags_model | out_flags;
      end
    end
  end

  initial begin
    int          seed_val;
    int          base;
    logic [31:0] a;
    logic [31:0] b;
    fp32_t       bw;

    rst_n       = 1'b0;
    in_valid    = 1'b0;
    op          = OP_ADD;
    rs1         = '0;
    rs2         = '0;
    flags_clr   = 1'b0;
    errors      = 0;
    flags_model = '0;
    seed_val    = $urandom(32'h9b7d8db9);
    fill_vectors();

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < N_VEC; i++) begin
      issue(vectors[i].op, vectors[i].a, vectors[i].b, i == CLR_AT, -1,
            vectors[i].exp_rd, vectors[i].exp_fl);
    end

    for (int i = 0; i < RAND_PAIRS; i++) begin
      a  = rand_normal();
      bw = rand_normal();
      // Equal exponents push the subtraction through deep cancellation.
      if (i % 2 == 1) begin
        bw.fields.exp = a[30:23];
      end
      b = (i % 25 == 0) ? a : bw.bits;
      issue(OP_ADD,  a, b, 1'b0, 5 * i,     '0, '0);
      issue(OP_ADD,  b, a, 1'b0, 5 * i + 1, '0, '0);
      issue(OP_SUB,  a, b, 1'b0, 5 * i + 2, '0, '0);
      issue(OP_RSUB, b, a, 1'b0, 5 * i + 3, '0, '0);
      issue(OP_SUB,  b, a, 1'b0, 5 * i + 4, '0, '0);
    end
    wait_drain();

    @(posedge clk);
    flags_clr <= 1'b1;
    @(posedge clk);
    flags_clr <= 1'b0;
    repeat (2) @(negedge clk);

    for (int i = 0; i < RAND_PAIRS; i++) begin
      base = 5 * i;
      check_val($sformatf("rand %0d add(b,a) rd", i), res_rd[base + 1], res_rd[base]);
      check_val($sformatf("rand %0d add(b,a) flags", i),
                32'(res_fl[base + 1]), 32'(res_fl[base]));
      check_val($sformatf("rand %0d rsub(b,a) rd", i), res_rd[base + 3], res_rd[base + 2]);
      if (res_rd[base + 2][30:0] != '0) begin
        check_val($sformatf("rand %0d sub(b,a) negated rd", i),
                  res_rd[base + 4] ^ 32'h80000000, res_rd[base + 2]);
      end
    end

    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: sources.f
fp_pkg.sv
fpu_ctrl.sv
fp_align.sv
fp_addmant.sv
fp_round.sv
fp_addsub_unit.sv
tb_fp_addsub.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module tb_fp_addsub \
  -o sim_tb_fp_addsub

./obj_dir/sim_tb_fp_addsub
